// File: Bender.yml
package:
  name: slow_cycle

sources:
  # Design, package first
  - files:
      - rtl/slowVramPkg.sv
      - rtl/cpuVramPort.sv
      - rtl/slotSequencer.sv
      - rtl/slowVram.sv
      - rtl/mapWordLatch.sv
      - rtl/slowCycle.sv

  # Testbench
  - target: test
    files:
      - testbench/slowCycleTb.sv

// File: rtl/cpuVramPort.sv
`timescale 1ns/100ps

module cpuVramPort
	import slowVramPkg::*;
#(
	parameter int CPU_FIFO_DEPTH = 4
)
(
	input logic CLK_24M,
	input logic rstN,
	input logic cpuReqValid,
	input cpuReq_t cpuReq,
	input slot_t slot,
	input phase_t phase,
	output logic cpuCredit,
	output vramAccess_t cpuAccess,
	output logic cpuRead
);

	localparam int PTR_W = $clog2(CPU_FIFO_DEPTH);

	cpuReq_t fifoMem [CPU_FIFO_DEPTH]; // Request storage
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W:0] fifoCount; // One extra bit for full
	cpuReq_t headReq;
	logic cpuSlotStart;
	logic popReq;
	logic headAccess; // Head is a read or write
	vramAddr_t addrPtr; // Auto-increment pointer
	vramAddr_t addrMod; // Step after each access
	portState_t portState;
	logic readQ; // Current slot carries a read

	assign cpuSlotStart = (slot == 2'd2) && (phase == 2'd0);
	assign popReq = cpuSlotStart && (fifoCount != '0);
	assign headReq = fifoMem[rdPtr];
	assign headAccess = popReq && ((headReq.op == OP_WRITE) || (headReq.op == OP_READ));
	assign cpuCredit = popReq; // Credit goes back on every pop

	// Storage, no reset needed for payload
	always_ff @(posedge CLK_24M)
	begin
		if (cpuReqValid)
			fifoMem[wrPtr] <= cpuReq;
	end

	always_ff @(posedge CLK_24M)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			fifoCount <= '0;
		end
		else
		begin
			if (cpuReqValid)
				wrPtr <= wrPtr + 1'b1; // Wraps, depth is a power of two
			if (popReq)
				rdPtr <= rdPtr + 1'b1;
			case ({cpuReqValid, popReq})
				2'b10: fifoCount <= fifoCount + 1'b1;
				2'b01: fifoCount <= fifoCount - 1'b1;
				default: fifoCount <= fifoCount; // Both or neither
			endcase
		end
	end

	// Access engine
	always_ff @(posedge CLK_24M)
	begin
		if (!rstN)
		begin
			portState <= PORT_IDLE;
			readQ <= 1'b0;
			addrPtr <= '0;
			addrMod <= 15'd1;
		end
		else
		begin
			case (portState)
				PORT_IDLE:
				begin
					if (popReq)
					begin
						case (headReq.op)
							OP_ADDR: addrPtr <= headReq.data[14:0];
							OP_MOD: addrMod <= headReq.data[14:0];
							default:
							begin
								portState <= PORT_ACCESS; // Hold address for rest of slot
								readQ <= (headReq.op == OP_READ);
							end
						endcase
					end
				end
				PORT_ACCESS:
				begin
					if (phase == 2'd3)
						portState <= PORT_DONE;
				end
				PORT_DONE:
				begin
					addrPtr <= addrPtr + addrMod; // 15-bit wrap
					readQ <= 1'b0;
					portState <= PORT_IDLE;
				end
				default: portState <= PORT_IDLE;
			endcase
		end
	end

	// Write strobe only in the pop cycle, address held through the slot
	always_comb
	begin
		cpuAccess.addr = addrPtr;
		cpuAccess.wrData = headAccess ? headReq.data : '0;
		cpuAccess.we = headAccess && (headReq.op == OP_WRITE);
	end

	assign cpuRead = (headAccess && (headReq.op == OP_READ)) ||
		((portState == PORT_ACCESS) && readQ);

	// Sender must hold a credit, so never a push into a full FIFO
	pushNotFull: assert property (@(posedge CLK_24M) disable iff (!rstN)
		cpuReqValid |-> (fifoCount != CPU_FIFO_DEPTH));

	// A started access runs to the end of slot 2 and no further
	accessInSlot: assert property (@(posedge CLK_24M) disable iff (!rstN)
		headAccess |=> (portState == PORT_ACCESS) [*3] ##1 (portState == PORT_DONE && slot == 2'd3));

endmodule

// File: rtl/mapWordLatch.sv
`timescale 1ns/100ps

module mapWordLatch
	import slowVramPkg::*;
(
	input logic CLK_24M,
	input logic rstN,
	input slot_t slot,
	input phase_t phase,
	input vramData_t rdData,
	input logic cpuRead,
	output sprTileNb_t sprTileNb,
	output sprAttr_t sprAttr,
	output logic sprValid,
	output fixTile_t fixTile,
	output logic fixValid,
	output vramData_t cpuRdData,
	output logic cpuRdValid
);

	vramData_t word0Q; // Sprite tile number low part
	logic capture; // Last phase of a slot

	assign capture = (phase == 2'd3);

	always_ff @(posedge CLK_24M)
	begin
		if (capture && (slot == 2'd0))
			word0Q <= rdData;
	end

	always_ff @(posedge CLK_24M)
	begin
		if (!rstN)
		begin
			sprTileNb <= '0;
			sprAttr <= '0;
			sprValid <= 1'b0;
			fixTile <= '0;
			fixValid <= 1'b0;
			cpuRdData <= '0;
			cpuRdValid <= 1'b0;
		end
		else
		begin
			sprValid <= capture && (slot == 2'd1);
			fixValid <= capture && (slot == 2'd3);
			cpuRdValid <= capture && (slot == 2'd2) && cpuRead;

			// Both words land together
			if (capture && (slot == 2'd1))
			begin
				sprTileNb <= {rdData[7:4], word0Q};
				sprAttr.pal <= rdData[15:8];
				sprAttr.aa <= rdData[3:2];
				sprAttr.flip <= rdData[1:0];
			end

			if (capture && (slot == 2'd3))
			begin
				fixTile.tile <= rdData[11:0];
				fixTile.pal <= rdData[15:12];
			end

			if (capture && (slot == 2'd2) && cpuRead)
				cpuRdData <= rdData; // Untouched when slot was idle or a write
		end
	end

	// Sprite and fix results half a round apart
	sprToFix: assert property (@(posedge CLK_24M) disable iff (!rstN)
		sprValid |-> ##8 fixValid);

endmodule

// File: rtl/slotSequencer.sv
`timescale 1ns/100ps

module slotSequencer
	import slowVramPkg::*;
(
	input logic CLK_24M,
	input logic rstN,
	input sprNb_t sprNb,
	input tileIdx_t tileIdx,
	input vramAddr_t fixMapAddr,
	input vramAccess_t cpuAccess,
	output slot_t slot,
	output phase_t phase,
	output vramAccess_t vramAccess
);

	logic [3:0] roundCnt; // Slot in upper bits, phase in lower
	sprNb_t sprNbQ;
	tileIdx_t tileIdxQ;
	vramAddr_t fixAddrQ;
	sprNb_t sprNbSel;
	tileIdx_t tileIdxSel;
	vramAddr_t fixAddrSel;
	logic sprSample;
	logic fixSample;

	assign slot = roundCnt[3:2];
	assign phase = roundCnt[1:0];
	assign sprSample = (slot == 2'd0) && (phase == 2'd0);
	assign fixSample = (slot == 2'd3) && (phase == 2'd0);

	always_ff @(posedge CLK_24M)
	begin
		if (!rstN)
			roundCnt <= '0; // Round starts at slot 0 phase 0
		else
			roundCnt <= roundCnt + 1'b1;
	end

	// Address inputs held for the slots that use them
	always_ff @(posedge CLK_24M)
	begin
		if (sprSample)
		begin
			sprNbQ <= sprNb;
			tileIdxQ <= tileIdx;
		end
		if (fixSample)
			fixAddrQ <= fixMapAddr;
	end

	// Live inputs in the sample cycle, latched copy afterwards
	assign sprNbSel = sprSample ? sprNb : sprNbQ;
	assign tileIdxSel = sprSample ? tileIdx : tileIdxQ;
	assign fixAddrSel = fixSample ? fixMapAddr : fixAddrQ;

	always_comb
	begin
		vramAccess = '0;
		case (slot)
			2'd0: vramAccess.addr = {sprNbSel, tileIdxSel, 1'b0}; // Tile number word
			2'd1: vramAccess.addr = {sprNbQ, tileIdxQ, 1'b1}; // Attribute word
			2'd2: vramAccess = cpuAccess; // Only slot with writes
			default: vramAccess.addr = fixAddrSel;
		endcase
	end

	// CPU write strobe must line up with phase 0 of the CPU slot
	weInCpuSlot: assert property (@(posedge CLK_24M) disable iff (!rstN)
		vramAccess.we |-> (slot == 2'd2) && (phase == 2'd0));

endmodule

// File: rtl/slowCycle.sv
`timescale 1ns/100ps

module slowCycle
	import slowVramPkg::*;
#(
	parameter int CPU_FIFO_DEPTH = 4
)
(
	input logic CLK_24M,
	input logic rstN,
	input logic cpuReqValid,
	input cpuReq_t cpuReq,
	output logic cpuCredit,
	input sprNb_t sprNb,
	input tileIdx_t tileIdx,
	input vramAddr_t fixMapAddr,
	output sprTileNb_t sprTileNb,
	output sprAttr_t sprAttr,
	output logic sprValid,
	output fixTile_t fixTile,
	output logic fixValid,
	output vramData_t cpuRdData,
	output logic cpuRdValid
);

	slot_t slot;
	phase_t phase;
	vramAccess_t cpuAccess; // From the CPU engine
	vramAccess_t vramAccess; // Muxed, to the array
	logic cpuRead;
	vramData_t rdData;

	cpuVramPort #(
		.CPU_FIFO_DEPTH(CPU_FIFO_DEPTH)
	) cpuVramPort_i (
		.CLK_24M(CLK_24M),
		.rstN(rstN),
		.cpuReqValid(cpuReqValid),
		.cpuReq(cpuReq),
		.slot(slot),
		.phase(phase),
		.cpuCredit(cpuCredit),
		.cpuAccess(cpuAccess),
		.cpuRead(cpuRead)
	);

	slotSequencer slotSequencer_i (
		.CLK_24M(CLK_24M),
		.rstN(rstN),
		.sprNb(sprNb),
		.tileIdx(tileIdx),
		.fixMapAddr(fixMapAddr),
		.cpuAccess(cpuAccess),
		.slot(slot),
		.phase(phase),
		.vramAccess(vramAccess)
	);

	slowVram slowVram_i (
		.CLK_24M(CLK_24M),
		.vramAccess(vramAccess),
		.rdData(rdData)
	);

	mapWordLatch mapWordLatch_i (
		.CLK_24M(CLK_24M),
		.rstN(rstN),
		.slot(slot),
		.phase(phase),
		.rdData(rdData),
		.cpuRead(cpuRead),
		.sprTileNb(sprTileNb),
		.sprAttr(sprAttr),
		.sprValid(sprValid),
		.fixTile(fixTile),
		.fixValid(fixValid),
		.cpuRdData(cpuRdData),
		.cpuRdValid(cpuRdValid)
	);

endmodule

// File: rtl/slowVram.sv
`timescale 1ns/100ps

module slowVram
	import slowVramPkg::*;
(
	input logic CLK_24M,
	input vramAccess_t vramAccess,
	output vramData_t rdData
);

	vramData_t mem [32768]; // 32K words

	// Single port, old data returned on a write
	always_ff @(posedge CLK_24M)
	begin
		if (vramAccess.we)
			mem[vramAccess.addr] <= vramAccess.wrData;
		rdData <= mem[vramAccess.addr];
	end

endmodule

// File: rtl/slowVramPkg.sv
package slowVramPkg;

	// Slow VRAM word address and data
	typedef logic [14:0] vramAddr_t;
	typedef logic [15:0] vramData_t;

	// Round position
	typedef logic [1:0] slot_t; // 0 spr word 0, 1 spr word 1, 2 CPU, 3 fix
	typedef logic [1:0] phase_t; // Clock within a slot

	// Sprite map addressing
	typedef logic [8:0] sprNb_t;
	typedef logic [4:0] tileIdx_t;
	typedef logic [19:0] sprTileNb_t;

	// CPU request kinds
	typedef logic [1:0] cpuOp_t;
	localparam cpuOp_t OP_ADDR = 2'd0; // Load pointer
	localparam cpuOp_t OP_MOD = 2'd1; // Load modulo
	localparam cpuOp_t OP_WRITE = 2'd2;
	localparam cpuOp_t OP_READ = 2'd3;

	typedef struct packed {
		cpuOp_t op;
		vramData_t data; // Low 15 bits only for OP_ADDR
	} cpuReq_t;

	typedef struct packed {
		vramAddr_t addr;
		vramData_t wrData;
		logic we;
	} vramAccess_t;

	// Attribute fields of sprite map word 1
	typedef struct packed {
		logic [7:0] pal;
		logic [1:0] aa; // Auto-animation
		logic [1:0] flip; // V and H flip
	} sprAttr_t;

	typedef struct packed {
		logic [11:0] tile;
		logic [3:0] pal;
	} fixTile_t;

	typedef enum logic [1:0] {
		PORT_IDLE,
		PORT_ACCESS,
		PORT_DONE
	} portState_t;

endpackage

// File: src.f
rtl/slowVramPkg.sv
rtl/cpuVramPort.sv
rtl/slotSequencer.sv
rtl/slowVram.sv
rtl/mapWordLatch.sv
rtl/slowCycle.sv
testbench/slowCycleTb.sv

// File: testbench/slowCycleInput.txt
# Command then hex fields. A addr, M modulo, W data, R expected, B count firstData
# S sprNb tileIdx expTileNb expPal expAa expFlip, F fixAddr expTile expPal
A 0100
M 0001
W 1111
W 2222
W 3333
M 0020
W AAAA
W BBBB
A 0100
M 0001
R 1111
R 2222
R 3333
R AAAA
A 0123
R BBBB
A 7FFD
M 0004
W 0D0D
W 0E0E
A 0001
R 0E0E
A 7FFD
R 0D0D
A 0486
M 0001
W BEEF
W 5A7D
S 012 03 7BEEF 5A 3 1
A 7FFE
W 0123
W C3A6
S 1FF 1F A0123 C3 1 2
A 7000
W 9ABC
W 1234
F 7000 ABC 9
F 7001 234 1
A 2000
B 8 5000
A 2000
R 5000
R 5001
R 5002
R 5003
R 5004
R 5005
R 5006
R 5007

// File: testbench/slowCycleTb.sv
`timescale 1ns/100ps

module slowCycleTb
	import slowVramPkg::*;
();

	localparam int CPU_FIFO_DEPTH = 4;
	localparam int VALID_LIMIT = 40; // More than two rounds of clocks
	localparam int CREDIT_LIMIT = 16 * (CPU_FIFO_DEPTH + 2);
	localparam int DRAIN_LIMIT = 16 * (CPU_FIFO_DEPTH + 3);

	logic CLK_24M;
	logic rstN;
	logic cpuReqValid;
	cpuReq_t cpuReq;
	logic cpuCredit;
	sprNb_t sprNb;
	tileIdx_t tileIdx;
	vramAddr_t fixMapAddr;
	sprTileNb_t sprTileNb;
	sprAttr_t sprAttr;
	logic sprValid;
	fixTile_t fixTile;
	logic fixValid;
	vramData_t cpuRdData;
	logic cpuRdValid;

	integer seed; // $random state
	int fd; // Stimulus file
	logic [31:0] fields [6]; // Hex fields of the current line
	int sentCnt; // Requests pushed
	int returnedCnt; // Credits seen back
	int maxOutstanding;
	vramData_t expRead [$]; // Expected read words in order
	int cycleCnt; // Clocks since reset release
	int lastSprCycle; // -1 until the first sprValid
	int sprPulseCnt;
	int fixPulseCnt;

	slowCycle #(
		.CPU_FIFO_DEPTH(CPU_FIFO_DEPTH)
	) slowCycle_i (
		.CLK_24M(CLK_24M),
		.rstN(rstN),
		.cpuReqValid(cpuReqValid),
		.cpuReq(cpuReq),
		.cpuCredit(cpuCredit),
		.sprNb(sprNb),
		.tileIdx(tileIdx),
		.fixMapAddr(fixMapAddr),
		.sprTileNb(sprTileNb),
		.sprAttr(sprAttr),
		.sprValid(sprValid),
		.fixTile(fixTile),
		.fixValid(fixValid),
		.cpuRdData(cpuRdData),
		.cpuRdValid(cpuRdValid)
	);

	initial
		CLK_24M = 1'b0;

	always #2 CLK_24M = ~CLK_24M; // 4 ns period

	task automatic abortRun(input string reason);
		$display("Error at %0t ns: %s", $time, reason);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("Fail at %0t ns: %s got %0h expected %0h", $time, what, actual, expected);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic int creditsAvail();
		return CPU_FIFO_DEPTH - (sentCnt - returnedCnt);
	endfunction

	// One request pulse while a credit is held
	task automatic sendReq(input cpuOp_t op, input vramData_t data, input bit withGap);
		int gap;
		int waitCnt;
		if (withGap)
		begin
			gap = $unsigned($random(seed)) % 4; // Idle clocks first
			repeat (gap) @(negedge CLK_24M);
		end
		waitCnt = 0;
		while (creditsAvail() == 0)
		begin
			@(negedge CLK_24M);
			waitCnt++;
			if (waitCnt > CREDIT_LIMIT)
				abortRun("no credit came back for a pending CPU request");
		end
		cpuReq.op = op;
		cpuReq.data = data;
		cpuReqValid = 1'b1;
		sentCnt++; // Spends a credit
		@(negedge CLK_24M);
		cpuReqValid = 1'b0;
	endtask

	// All credits home and every read answered
	task automatic drainCpu();
		int waitCnt;
		waitCnt = 0;
		while ((creditsAvail() != CPU_FIFO_DEPTH) || (expRead.size() != 0))
		begin
			@(negedge CLK_24M);
			waitCnt++;
			if (waitCnt > DRAIN_LIMIT)
				abortRun("CPU requests did not drain in time");
		end
	endtask

	task automatic waitValid(input bit useFix, input string what);
		int waitCnt;
		waitCnt = 0;
		do
		begin
			@(negedge CLK_24M);
			waitCnt++;
			if (waitCnt > VALID_LIMIT)
				abortRun({"timeout waiting for ", what});
		end
		while ((useFix ? fixValid : sprValid) !== 1'b1);
	endtask

	task automatic readFields(input int n);
		int k;
		int code;
		for (k = 0; k < n; k++)
		begin
			code = $fscanf(fd, " %h", fields[k]);
			if (code != 1)
				abortRun("malformed line in stimulus file");
		end
	endtask

	task automatic runCommand(input logic [7:0] cmd);
		int k;
		string rest;
		case (cmd)
			"#": k = $fgets(rest, fd); // Comment line
			"A":
			begin
				readFields(1);
				sendReq(OP_ADDR, fields[0][15:0], 1'b1);
			end
			"M":
			begin
				readFields(1);
				sendReq(OP_MOD, fields[0][15:0], 1'b1);
			end
			"W":
			begin
				readFields(1);
				sendReq(OP_WRITE, fields[0][15:0], 1'b1);
			end
			"R":
			begin
				readFields(1);
				expRead.push_back(fields[0][15:0]);
				sendReq(OP_READ, '0, 1'b1);
			end
			"B":
			begin
				readFields(2);
				maxOutstanding = sentCnt - returnedCnt; // Peak of this burst only
				for (k = 0; k < fields[0]; k++)
					sendReq(OP_WRITE, vramData_t'(fields[1][15:0] + k), 1'b0); // Back to back
				drainCpu();
				checkValue(maxOutstanding, CPU_FIFO_DEPTH, "peak outstanding requests");
			end
			"S":
			begin
				readFields(6);
				drainCpu(); // Map words written before the round reads them
				sprNb = fields[0][8:0];
				tileIdx = fields[1][4:0];
				waitValid(1'b1, "fixValid before sprite round"); // Round start samples inputs
				waitValid(1'b0, "sprValid");
				checkValue(sprTileNb, fields[2], "sprite tile number");
				checkValue(sprAttr.pal, fields[3], "sprite palette");
				checkValue(sprAttr.aa, fields[4], "sprite auto-animation");
				checkValue(sprAttr.flip, fields[5], "sprite flip");
			end
			"F":
			begin
				readFields(3);
				drainCpu();
				fixMapAddr = fields[0][14:0];
				waitValid(1'b0, "sprValid before fix slot"); // Fix sample lies after this
				waitValid(1'b1, "fixValid");
				checkValue(fixTile.tile, fields[1], "fix tile");
				checkValue(fixTile.pal, fields[2], "fix palette");
			end
			default: abortRun("unknown command in stimulus file");
		endcase
	endtask

	// Monitors sample at the rising edge before the DUT updates
	always @(posedge CLK_24M)
	begin
		if (rstN === 1'b1)
		begin
			if (cpuCredit === 1'b1)
				returnedCnt++;
			if (returnedCnt > sentCnt)
				abortRun("credit returned with no request outstanding");
			if (sentCnt - returnedCnt > maxOutstanding)
				maxOutstanding = sentCnt - returnedCnt;
			if (cpuRdValid === 1'b1)
			begin
				if (expRead.size() == 0)
					abortRun("cpuRdValid with no read pending");
				checkValue(cpuRdData, expRead.pop_front(), "CPU read data");
			end
		end
	end

	// Round cadence of the video results
	always @(posedge CLK_24M)
	begin
		if (rstN !== 1'b1)
		begin
			cycleCnt = 0;
			lastSprCycle = -1;
			sprPulseCnt = 0;
			fixPulseCnt = 0;
		end
		else
		begin
			cycleCnt++;
			if ((lastSprCycle >= 0) && (cycleCnt - lastSprCycle > 16))
				abortRun("sprValid missing for more than 16 clocks");
			if (sprValid === 1'b1)
			begin
				if (lastSprCycle >= 0)
					checkValue(cycleCnt - lastSprCycle, 16, "sprValid period");
				checkValue(fixPulseCnt, sprPulseCnt, "fixValid pulses per round");
				lastSprCycle = cycleCnt;
				sprPulseCnt++;
			end
			if (fixValid === 1'b1)
			begin
				if (lastSprCycle < 0)
					abortRun("fixValid seen before any sprValid");
				checkValue(cycleCnt - lastSprCycle, 8, "fixValid offset from sprValid");
				fixPulseCnt++;
			end
		end
	end

	initial
	begin : mainFlow
		logic [7:0] cmd;
		int code;
		int i;
		seed = 32'hdecd_c866;
		sentCnt = 0;
		returnedCnt = 0;
		maxOutstanding = 0;
		rstN = 1'b0;
		cpuReqValid = 1'b0;
		cpuReq = '0;
		sprNb = '0;
		tileIdx = '0;
		fixMapAddr = '0;
		repeat (3) @(negedge CLK_24M); // Reset length
		checkValue(sprTileNb, 0, "sprTileNb in reset");
		checkValue(sprAttr, 0, "sprAttr in reset");
		checkValue(fixTile, 0, "fixTile in reset");
		checkValue(cpuRdData, 0, "cpuRdData in reset");
		checkValue({cpuCredit, sprValid, fixValid, cpuRdValid}, 0, "strobes in reset");
		rstN = 1'b1;

		// Quiet CPU side until the first request
		// No video result early in round 0
		for (i = 0; i < 32; i++)
		begin
			@(negedge CLK_24M);
			checkValue(cpuCredit, 0, "cpuCredit before first request");
			checkValue(cpuRdValid, 0, "cpuRdValid before first request");
			if (i < 7)
				checkValue({sprValid, fixValid}, 0, "video strobes early in round 0");
		end

		fd = $fopen("testbench/slowCycleInput.txt", "r");
		if (fd == 0)
			abortRun("cannot open testbench/slowCycleInput.txt");
		code = $fscanf(fd, " %c", cmd);
		while (code == 1)
		begin
			runCommand(cmd);
			code = $fscanf(fd, " %c", cmd);
		end
		$fclose(fd);
		drainCpu();
		for (i = 0; i < 40; i++)
			@(negedge CLK_24M); // Let the cadence monitor see more rounds

		if ((sprPulseCnt > 10) && (fixPulseCnt > 10))
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
		else
			abortRun("too few sprite or fix result pulses");
	end

endmodule
